//--- cache_mem_pkg.sv
/*
  shared widths and word types for the cache_mem subsystem
  word and address widths are fixed at 32 bits
  SRAM depth is not here, it is a module parameter set at the top level
*/
`default_nettype none

package cache_mem_pkg;

  // **********************************************************************
  // widths
  // **********************************************************************

  // one data word
  localparam int DATA_W = 32;

  // byte address, word aligned accesses only
  localparam int ADDR_W = 32;

  // one enable per byte lane
  localparam int BE_W = DATA_W / 8;

  // **********************************************************************
  // word types
  // **********************************************************************

  // data word as seen on every bus in the design
  typedef logic [DATA_W-1:0] word_t;

  // byte address, bits 1:0 are ignored by the SRAM
  typedef logic [ADDR_W-1:0] addr_t;

  // byte enables, bit n covers data bits 8n+7 down to 8n
  typedef logic [BE_W-1:0] be_t;

endpackage

`default_nettype wire

//--- shared_sram.sv
/*
  single port word SRAM, cleared to zero by reset
  SRAM_DEPTH must be a power of two, at least 2
  address bits above the depth are ignored, so addresses wrap
  read data is combinational and forced to zero when not selected
*/
`timescale 1ns/1ps
`default_nettype none

module shared_sram #(
  parameter int SRAM_DEPTH = 1024
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 sram_sel,
  input  logic                 sram_we,
  input  cache_mem_pkg::addr_t sram_addr,
  input  cache_mem_pkg::word_t sram_wdata,
  output cache_mem_pkg::word_t sram_rdata
);

  // word index width from the depth
  localparam int IDX_W = $clog2(SRAM_DEPTH);

  // storage
  cache_mem_pkg::word_t mem [SRAM_DEPTH];

  // word index, byte offset bits dropped
  logic [IDX_W-1:0] idx;

  // upper bits beyond the depth fall away here
  assign idx = sram_addr[IDX_W+1:2];

  // **********************************************************************
  // write port
  // **********************************************************************

  // whole array cleared on reset
  // write when selected and write enabled
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < SRAM_DEPTH; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (sram_sel && sram_we)
    begin
      mem[idx] <= sram_wdata;
    end
  end

  // **********************************************************************
  // read port
  // **********************************************************************

  // same index as the write, zero when idle
  assign sram_rdata = sram_sel ? mem[idx] : '0;

endmodule

`default_nettype wire

//--- mem_bus_arbiter.sv
/*
  round-robin arbiter between the fetch and data ports, four-phase on both
  a write commits once, at the first edge of the D ack window
  wr_addr names the fetch buffer's alias when the write hits the same SRAM word
*/
`timescale 1ns/1ps
`default_nettype none

module mem_bus_arbiter #(
  parameter int SRAM_DEPTH = 1024
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 i_req,
  input  cache_mem_pkg::addr_t i_addr,
  output logic                 i_ack,
  input  logic                 d_req,
  input  logic                 d_we,
  input  cache_mem_pkg::addr_t d_addr,
  input  cache_mem_pkg::word_t d_wdata,
  output logic                 d_ack,
  output cache_mem_pkg::word_t bus_rdata,
  output logic                 sram_sel,
  output logic                 sram_we,
  output cache_mem_pkg::addr_t sram_addr,
  output cache_mem_pkg::word_t sram_wdata,
  input  cache_mem_pkg::word_t sram_rdata,
  output logic                 wr_strobe,
  output cache_mem_pkg::addr_t wr_addr
);

  localparam int IDX_W = $clog2(SRAM_DEPTH);

  // fsm encoding
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_GNT_I = 2'd1;
  localparam logic [1:0] ST_GNT_D = 2'd2;
  localparam logic [1:0] ST_REL   = 2'd3;

  logic [1:0]           state;
  // 1 when the last grant went to the data port
  logic                 last_d;
  // address of the last fetch served, which is what the fetch buffer holds
  cache_mem_pkg::addr_t last_i_addr;
  logic                 sel_d;
  logic                 alias_hit;

  // **********************************************************************
  // grant fsm
  // **********************************************************************

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= ST_IDLE;
      last_d      <= 1'b0;
      last_i_addr <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          // on a tie the port not served last wins
          if (i_req && (!d_req || last_d))
          begin
            state       <= ST_GNT_I;
            last_d      <= 1'b0;
            last_i_addr <= i_addr;
          end
          else if (d_req)
          begin
            state  <= ST_GNT_D;
            last_d <= 1'b1;
          end
        end
        // first ack cycle, write commits at its closing edge
        ST_GNT_I: state <= i_req ? ST_REL : ST_IDLE;
        ST_GNT_D: state <= d_req ? ST_REL : ST_IDLE;
        // ack held until the owner drops req
        default:
        begin
          if (last_d ? !d_req : !i_req)
          begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // owner of the bus in REL is the last grant
  assign sel_d = (state == ST_GNT_D) || ((state == ST_REL) && last_d);
  assign i_ack = (state == ST_GNT_I) || ((state == ST_REL) && !last_d);
  assign d_ack = sel_d;

  // **********************************************************************
  // sram mux
  // **********************************************************************

  assign sram_sel   = (state != ST_IDLE);
  assign sram_addr  = sel_d ? d_addr : i_addr;
  // only in the first D cycle, never repeated while ack is held
  assign sram_we    = (state == ST_GNT_D) && d_we;
  assign sram_wdata = d_wdata;
  assign bus_rdata  = sram_rdata;

  // snoop strobe, same cycle as the commit
  assign wr_strobe = sram_we;
  // same SRAM word as the buffered fetch, possibly through wrap
  assign alias_hit = (d_addr[IDX_W+1:2] == last_i_addr[IDX_W+1:2]);
  assign wr_addr   = alias_hit ? last_i_addr : d_addr;

endmodule

`default_nettype wire

//--- inst_fetch_port.sv
/*
  read-only fetch port with a one-word prefetch buffer
  a hit acks one cycle after fetch_req, a miss runs one bus read
  snooped writes to the buffered word invalidate it, also during a fill
*/
`timescale 1ns/1ps
`default_nettype none

module inst_fetch_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fetch_req,
  input  cache_mem_pkg::addr_t fetch_addr,
  output logic                 fetch_ack,
  output cache_mem_pkg::word_t fetch_data,
  output logic                 i_req,
  output cache_mem_pkg::addr_t i_addr,
  input  logic                 i_ack,
  input  cache_mem_pkg::word_t bus_rdata,
  input  logic                 wr_strobe,
  input  cache_mem_pkg::addr_t wr_addr
);

  localparam int AW = cache_mem_pkg::ADDR_W;

  // fsm encoding
  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_BUS_REQ = 2'd1;
  localparam logic [1:0] ST_BUS_REL = 2'd2;
  localparam logic [1:0] ST_ACK     = 2'd3;

  logic [1:0]           state;
  logic                 buf_valid;
  cache_mem_pkg::addr_t buf_addr;
  cache_mem_pkg::word_t buf_data;
  // set when a snoop hits the word being filled
  logic                 fill_kill;
  logic                 snoop_hit;
  logic                 hit;

  // word compare only, byte offset ignored
  assign snoop_hit = wr_strobe && (wr_addr[AW-1:2] == buf_addr[AW-1:2]);
  // a write in the same cycle beats the hit
  assign hit = buf_valid && !snoop_hit && (fetch_addr[AW-1:2] == buf_addr[AW-1:2]);

  // **********************************************************************
  // fetch fsm
  // **********************************************************************

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= ST_IDLE;
      buf_valid <= 1'b0;
      fill_kill <= 1'b0;
    end
    else
    begin
      // snoop runs in every state
      if (snoop_hit)
      begin
        buf_valid <= 1'b0;
      end
      case (state)
        ST_IDLE:
        begin
          if (fetch_req && hit)
          begin
            state <= ST_ACK;
          end
          else if (fetch_req)
          begin
            // miss, retarget the buffer
            state     <= ST_BUS_REQ;
            buf_valid <= 1'b0;
            fill_kill <= 1'b0;
          end
        end
        ST_BUS_REQ:
        begin
          if (snoop_hit)
          begin
            fill_kill <= 1'b1;
          end
          if (i_ack)
          begin
            // data still goes to the core, only validity is dropped
            state     <= ST_BUS_REL;
            buf_valid <= !fill_kill && !snoop_hit;
          end
        end
        ST_BUS_REL:
        begin
          if (!i_ack)
          begin
            state <= ST_ACK;
          end
        end
        default:
        begin
          if (!fetch_req)
          begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // buffer payload
  always_ff @(posedge clk)
  begin
    if ((state == ST_IDLE) && fetch_req && !hit)
    begin
      buf_addr <= fetch_addr;
    end
    if ((state == ST_BUS_REQ) && i_ack)
    begin
      buf_data <= bus_rdata;
    end
  end

  assign fetch_ack  = (state == ST_ACK);
  assign fetch_data = buf_data;
  // buffered address is stable for the whole bus handshake
  assign i_req      = (state == ST_BUS_REQ);
  assign i_addr     = buf_addr;

endmodule

`default_nettype wire

//--- data_access_port.sv
/*
  data port with byte enables over a four-phase bus link
  a read or a full-word write is one bus transaction
  a partial write is a read followed by a merged write, not atomic
  against fetch traffic in between, which never writes
*/
`timescale 1ns/1ps
`default_nettype none

module data_access_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 data_req,
  input  logic                 data_we,
  input  cache_mem_pkg::be_t   data_be,
  input  cache_mem_pkg::addr_t data_addr,
  input  cache_mem_pkg::word_t data_wdata,
  output logic                 data_ack,
  output cache_mem_pkg::word_t data_rdata,
  output logic                 d_req,
  output logic                 d_we,
  output cache_mem_pkg::addr_t d_addr,
  output cache_mem_pkg::word_t d_wdata,
  input  logic                 d_ack,
  input  cache_mem_pkg::word_t bus_rdata
);

  localparam int BE_W = cache_mem_pkg::BE_W;

  // fsm encoding
  localparam logic [2:0] ST_IDLE   = 3'd0;
  localparam logic [2:0] ST_RD_REQ = 3'd1;
  localparam logic [2:0] ST_RD_REL = 3'd2;
  localparam logic [2:0] ST_WR_REQ = 3'd3;
  localparam logic [2:0] ST_WR_REL = 3'd4;
  localparam logic [2:0] ST_ACK    = 3'd5;

  logic [2:0]           state;
  // every lane enabled, no read needed
  logic                 full_wr;
  cache_mem_pkg::word_t merged;
  cache_mem_pkg::word_t rdata_q;
  cache_mem_pkg::word_t wdata_q;

  assign full_wr = data_we && (&data_be);

  // **********************************************************************
  // byte merge
  // **********************************************************************

  // enabled lanes from the core, the rest from the old word
  always_comb
  begin
    for (int b = 0; b < BE_W; b++)
    begin
      merged[8*b +: 8] = data_be[b] ? data_wdata[8*b +: 8] : bus_rdata[8*b +: 8];
    end
  end

  // **********************************************************************
  // sequencer
  // **********************************************************************

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= ST_IDLE;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (data_req)
          begin
            state <= full_wr ? ST_WR_REQ : ST_RD_REQ;
          end
        end
        ST_RD_REQ:
        begin
          if (d_ack)
          begin
            state <= ST_RD_REL;
          end
        end
        ST_RD_REL:
        begin
          // partial write continues with the merged word
          if (!d_ack)
          begin
            state <= data_we ? ST_WR_REQ : ST_ACK;
          end
        end
        ST_WR_REQ:
        begin
          if (d_ack)
          begin
            state <= ST_WR_REL;
          end
        end
        ST_WR_REL:
        begin
          if (!d_ack)
          begin
            state <= ST_ACK;
          end
        end
        default:
        begin
          // wait for the core to drop its request
          if (!data_req)
          begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // payload, loaded once per operation
  always_ff @(posedge clk)
  begin
    if ((state == ST_IDLE) && data_req && full_wr)
    begin
      wdata_q <= data_wdata;
    end
    if ((state == ST_RD_REQ) && d_ack)
    begin
      rdata_q <= bus_rdata;
      wdata_q <= merged;
    end
  end

  assign d_req   = (state == ST_RD_REQ) || (state == ST_WR_REQ);
  // held through the release phase so it is stable until ack falls
  assign d_we    = (state == ST_WR_REQ) || (state == ST_WR_REL);
  assign d_addr  = data_addr;
  assign d_wdata = wdata_q;

  assign data_ack   = (state == ST_ACK);
  // old word on a partial write
  assign data_rdata = rdata_q;

endmodule

`default_nettype wire

//--- cache_mem_top.sv
/*
  memory subsystem top, fetch and data ports sharing one SRAM
  SRAM_DEPTH must be a power of two, addresses wrap at the depth
  all latencies vary, completion is marked by fetch_ack and data_ack
*/
`timescale 1ns/1ps
`default_nettype none

module cache_mem_top #(
  parameter int SRAM_DEPTH = 1024
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fetch_req,
  input  cache_mem_pkg::addr_t fetch_addr,
  output logic                 fetch_ack,
  output cache_mem_pkg::word_t fetch_data,
  input  logic                 data_req,
  input  logic                 data_we,
  input  cache_mem_pkg::be_t   data_be,
  input  cache_mem_pkg::addr_t data_addr,
  input  cache_mem_pkg::word_t data_wdata,
  output logic                 data_ack,
  output cache_mem_pkg::word_t data_rdata
);

  // fetch port to arbiter
  logic                 i_req;
  cache_mem_pkg::addr_t i_addr;
  logic                 i_ack;
  // data port to arbiter
  logic                 d_req;
  logic                 d_we;
  cache_mem_pkg::addr_t d_addr;
  cache_mem_pkg::word_t d_wdata;
  logic                 d_ack;
  // shared read return
  cache_mem_pkg::word_t bus_rdata;
  // arbiter to sram
  logic                 sram_sel;
  logic                 sram_we;
  cache_mem_pkg::addr_t sram_addr;
  cache_mem_pkg::word_t sram_wdata;
  cache_mem_pkg::word_t sram_rdata;
  // write snoop
  logic                 wr_strobe;
  cache_mem_pkg::addr_t wr_addr;

  // **********************************************************************
  // ports
  // **********************************************************************

  inst_fetch_port u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .fetch_ack  (fetch_ack),
    .fetch_data (fetch_data),
    .i_req      (i_req),
    .i_addr     (i_addr),
    .i_ack      (i_ack),
    .bus_rdata  (bus_rdata),
    .wr_strobe  (wr_strobe),
    .wr_addr    (wr_addr)
  );

  data_access_port u_data (
    .clk        (clk),
    .rst_n      (rst_n),
    .data_req   (data_req),
    .data_we    (data_we),
    .data_be    (data_be),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_ack   (data_ack),
    .data_rdata (data_rdata),
    .d_req      (d_req),
    .d_we       (d_we),
    .d_addr     (d_addr),
    .d_wdata    (d_wdata),
    .d_ack      (d_ack),
    .bus_rdata  (bus_rdata)
  );

  // **********************************************************************
  // arbiter and storage
  // **********************************************************************

  mem_bus_arbiter #(
    .SRAM_DEPTH (SRAM_DEPTH)
  ) u_arb (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_req      (i_req),
    .i_addr     (i_addr),
    .i_ack      (i_ack),
    .d_req      (d_req),
    .d_we       (d_we),
    .d_addr     (d_addr),
    .d_wdata    (d_wdata),
    .d_ack      (d_ack),
    .bus_rdata  (bus_rdata),
    .sram_sel   (sram_sel),
    .sram_we    (sram_we),
    .sram_addr  (sram_addr),
    .sram_wdata (sram_wdata),
    .sram_rdata (sram_rdata),
    .wr_strobe  (wr_strobe),
    .wr_addr    (wr_addr)
  );

  shared_sram #(
    .SRAM_DEPTH (SRAM_DEPTH)
  ) u_sram (
    .clk        (clk),
    .rst_n      (rst_n),
    .sram_sel   (sram_sel),
    .sram_we    (sram_we),
    .sram_addr  (sram_addr),
    .sram_wdata (sram_wdata),
    .sram_rdata (sram_rdata)
  );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
/*
  testbench clock and reset source
  reset is low for RESET_CYCLES rising edges, released 1 ns after an edge
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  // free running clock
  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // short high pulse first so every simulator sees a falling edge
  initial
  begin
    rst_n = 1'b1;
    #1;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- cache_mem_sva.sv
/*
  handshake assertions for mem_bus_arbiter, attached by bind
  all checks are sampled on the rising clock and disabled in reset
*/
`timescale 1ns/1ps
`default_nettype none

module cache_mem_sva (
  input logic clk,
  input logic rst_n,
  input logic i_req,
  input logic i_ack,
  input logic d_req,
  input logic d_ack,
  input logic sram_we
);

  // **********************************************************************
  // four-phase rules
  // **********************************************************************

  // ack only answers a live request
  a_i_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(i_ack) |-> i_req)
    else $error("i_ack rose while i_req was low");
  a_d_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(d_ack) |-> d_req)
    else $error("d_ack rose while d_req was low");

  // ack released only once the owner has let go
  a_i_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(i_ack) |-> !$past(i_req))
    else $error("i_ack fell while i_req was still high");
  a_d_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(d_ack) |-> !$past(d_req))
    else $error("d_ack fell while d_req was still high");

  // **********************************************************************
  // bus ownership
  // **********************************************************************

  // one owner at a time
  a_one_ack: assert property (@(posedge clk) disable iff (!rst_n) !(i_ack && d_ack))
    else $error("i_ack and d_ack high together");

  // writes come from the data port in the first cycle of its grant
  a_we_in_d: assert property (@(posedge clk) disable iff (!rst_n)
    sram_we |-> $rose(d_ack) && d_req)
    else $error("sram_we high outside the first cycle of a data grant");

endmodule

`default_nettype wire

//--- cache_mem_tb.sv
/*
  table-driven testbench for cache_mem_top with SRAM_DEPTH 1024
  expected values come from a sparse word model using the byte-merge rule
  random section keeps fetch words and data words apart, so no race on a word
*/
`timescale 1ns/1ps
`default_nettype none

module cache_mem_tb;

  localparam int SRAM_DEPTH = 1024;
  localparam int CLK_NS     = 4;
  localparam int N_TAB      = 20;
  localparam int N_PRE      = 16;
  localparam int N_RND      = 40;
  // table, preload and both random streams
  localparam int N_OPS      = N_TAB + N_PRE + 2 * N_RND;
  localparam int LIMIT_CYC  = N_OPS * 40;

  typedef struct packed {
    logic                 is_d;
    logic                 we;
    cache_mem_pkg::be_t   be;
    cache_mem_pkg::addr_t addr;
    cache_mem_pkg::word_t wdata;
    logic                 use_model;
    cache_mem_pkg::word_t exp;
  } entry_t;

  logic                 clk;
  logic                 rst_n;
  logic                 fetch_req;
  cache_mem_pkg::addr_t fetch_addr;
  logic                 fetch_ack;
  cache_mem_pkg::word_t fetch_data;
  logic                 data_req;
  logic                 data_we;
  cache_mem_pkg::be_t   data_be;
  cache_mem_pkg::addr_t data_addr;
  cache_mem_pkg::word_t data_wdata;
  logic                 data_ack;
  cache_mem_pkg::word_t data_rdata;

  entry_t               stim [N_TAB];
  // sparse model keyed by word index after wrap
  cache_mem_pkg::word_t model [int];
  int                   errors;
  int                   checks;
  int                   tests;
  integer               seed;
  logic [31:0]          rnd_d [N_RND];
  logic [31:0]          rnd_w [N_RND];
  logic [31:0]          rnd_i [N_RND];

  tb_clock_gen #(
    .PERIOD_NS    (CLK_NS),
    .RESET_CYCLES (3)
  ) u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  cache_mem_top #(
    .SRAM_DEPTH (SRAM_DEPTH)
  ) u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .fetch_ack  (fetch_ack),
    .fetch_data (fetch_data),
    .data_req   (data_req),
    .data_we    (data_we),
    .data_be    (data_be),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_ack   (data_ack),
    .data_rdata (data_rdata)
  );

  bind mem_bus_arbiter cache_mem_sva u_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_req   (i_req),
    .i_ack   (i_ack),
    .d_req   (d_req),
    .d_ack   (d_ack),
    .sram_we (sram_we)
  );

  // **********************************************************************
  // memory model
  // **********************************************************************

  // bits above the depth fall away
  function automatic int word_index(input cache_mem_pkg::addr_t addr);
    return int'((addr >> 2) % SRAM_DEPTH);
  endfunction

  // unwritten words read as zero after reset
  function automatic cache_mem_pkg::word_t model_read(input cache_mem_pkg::addr_t addr);
    if (model.exists(word_index(addr)))
    begin
      return model[word_index(addr)];
    end
    return '0;
  endfunction

  // enabled bytes new, the rest kept
  function automatic void model_write(input cache_mem_pkg::addr_t addr,
                                      input cache_mem_pkg::be_t be,
                                      input cache_mem_pkg::word_t wdata);
    cache_mem_pkg::word_t w;
    w = model_read(addr);
    for (int b = 0; b < cache_mem_pkg::BE_W; b++)
    begin
      if (be[b])
      begin
        w[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    model[word_index(addr)] = w;
  endfunction

  task automatic check_value(input string name, input cache_mem_pkg::word_t exp,
                             input cache_mem_pkg::word_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // **********************************************************************
  // four-phase drivers that change inputs 1 ns after the rising edge
  // **********************************************************************

  task automatic fetch_op(input cache_mem_pkg::addr_t addr, output cache_mem_pkg::word_t data);
    @(posedge clk);
    #1;
    fetch_addr = addr;
    fetch_req  = 1'b1;
    @(posedge clk);
    #1;
    while (!fetch_ack)
    begin
      @(posedge clk);
      #1;
    end
    data      = fetch_data;
    fetch_req = 1'b0;
    @(posedge clk);
    #1;
    while (fetch_ack)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // operands held until the next operation
  task automatic data_op(input logic we, input cache_mem_pkg::be_t be,
                         input cache_mem_pkg::addr_t addr, input cache_mem_pkg::word_t wdata,
                         output cache_mem_pkg::word_t rdata);
    @(posedge clk);
    #1;
    data_we    = we;
    data_be    = be;
    data_addr  = addr;
    data_wdata = wdata;
    data_req   = 1'b1;
    @(posedge clk);
    #1;
    while (!data_ack)
    begin
      @(posedge clk);
      #1;
    end
    rdata    = data_rdata;
    data_req = 1'b0;
    @(posedge clk);
    #1;
    while (data_ack)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // **********************************************************************
  // directed table
  // **********************************************************************

  task automatic load_table();
    // is_d, we, be, addr, wdata, use_model, exp
    stim[0]  = '{1'b0, 1'b0, 4'h0, 32'h0000_0000, 32'h0, 1'b0, 32'h0};
    stim[1]  = '{1'b1, 1'b0, 4'hf, 32'h0000_0040, 32'h0, 1'b0, 32'h0};
    stim[2]  = '{1'b0, 1'b0, 4'h0, 32'h0000_0ffc, 32'h0, 1'b0, 32'h0};
    // full word read back through both ports
    stim[3]  = '{1'b1, 1'b1, 4'hf, 32'h0000_0010, 32'hdead_beef, 1'b1, 32'h0};
    stim[4]  = '{1'b1, 1'b0, 4'hf, 32'h0000_0010, 32'h0, 1'b1, 32'h0};
    stim[5]  = '{1'b0, 1'b0, 4'h0, 32'h0000_0010, 32'h0, 1'b1, 32'h0};
    // partial write over the buffered word
    stim[6]  = '{1'b1, 1'b1, 4'h5, 32'h0000_0010, 32'h1122_3344, 1'b1, 32'h0};
    stim[7]  = '{1'b1, 1'b0, 4'hf, 32'h0000_0010, 32'h0, 1'b1, 32'h0};
    stim[8]  = '{1'b0, 1'b0, 4'h0, 32'h0000_0010, 32'h0, 1'b1, 32'h0};
    stim[9]  = '{1'b0, 1'b0, 4'h0, 32'h0000_0010, 32'h0, 1'b1, 32'h0};
    stim[10] = '{1'b1, 1'b1, 4'h8, 32'h0000_0020, 32'haa55_1234, 1'b1, 32'h0};
    stim[11] = '{1'b1, 1'b0, 4'hf, 32'h0000_0020, 32'h0, 1'b1, 32'h0};
    // high wrap alias written and low alias read
    stim[12] = '{1'b1, 1'b1, 4'hf, 32'h0000_1008, 32'hcafe_f00d, 1'b1, 32'h0};
    stim[13] = '{1'b1, 1'b0, 4'hf, 32'h0000_0008, 32'h0, 1'b1, 32'h0};
    stim[14] = '{1'b0, 1'b0, 4'h0, 32'h0000_0008, 32'h0, 1'b1, 32'h0};
    // and the reverse
    stim[15] = '{1'b1, 1'b1, 4'hf, 32'h0000_000c, 32'h1234_5678, 1'b1, 32'h0};
    stim[16] = '{1'b1, 1'b0, 4'hf, 32'h0000_100c, 32'h0, 1'b1, 32'h0};
    stim[17] = '{1'b0, 1'b0, 4'h0, 32'h0000_100c, 32'h0, 1'b1, 32'h0};
    // snoop through the wrap alias
    stim[18] = '{1'b1, 1'b1, 4'h3, 32'h0000_000c, 32'h0000_abcd, 1'b1, 32'h0};
    stim[19] = '{1'b0, 1'b0, 4'h0, 32'h0000_100c, 32'h0, 1'b1, 32'h0};
  endtask

  task automatic run_entry(input int n);
    entry_t               e;
    cache_mem_pkg::word_t got;
    cache_mem_pkg::word_t exp;
    int                   err0;
    e    = stim[n];
    err0 = errors;
    if (e.is_d)
    begin
      data_op(e.we, e.be, e.addr, e.wdata, got);
    end
    else
    begin
      fetch_op(e.addr, got);
    end
    if (e.is_d && e.we)
    begin
      model_write(e.addr, e.be, e.wdata);
    end
    else
    begin
      exp = e.use_model ? model_read(e.addr) : e.exp;
      check_value(e.is_d ? "data_rdata" : "fetch_data", exp, got);
    end
    tests++;
    $display("test %0d %s %s addr %h: %s", tests, e.is_d ? "data" : "fetch",
             (e.is_d && e.we) ? "write" : "read", e.addr, (errors == err0) ? "ok" : "FAIL");
  endtask

  // **********************************************************************
  // random streams
  // **********************************************************************

  // data words 0x80..0xbf and their wrap aliases
  task automatic data_stream();
    cache_mem_pkg::addr_t addr;
    cache_mem_pkg::word_t got;
    logic [31:0]          r;
    int                   err0;
    for (int k = 0; k < N_RND; k++)
    begin
      r    = rnd_d[k];
      err0 = errors;
      addr = 32'h200 + {24'd0, r[5:0], 2'b00};
      if (r[6])
      begin
        addr = addr + 32'h1000;
      end
      repeat (r[13:12]) @(posedge clk);
      data_op(r[7], r[11:8], addr, rnd_w[k], got);
      if (r[7])
      begin
        model_write(addr, r[11:8], rnd_w[k]);
      end
      else
      begin
        check_value("data_rdata", model_read(addr), got);
      end
      tests++;
      $display("test %0d random data addr %h: %s", tests, addr, (errors == err0) ? "ok" : "FAIL");
    end
  endtask

  // fetch words 0xc0..0xcf that the preload fills
  task automatic fetch_stream();
    cache_mem_pkg::addr_t addr;
    cache_mem_pkg::word_t got;
    logic [31:0]          r;
    int                   err0;
    for (int k = 0; k < N_RND; k++)
    begin
      r    = rnd_i[k];
      err0 = errors;
      addr = 32'h300 + {26'd0, r[3:0], 2'b00};
      if (r[4])
      begin
        addr = addr + 32'h1000;
      end
      repeat (r[6:5]) @(posedge clk);
      fetch_op(addr, got);
      check_value("fetch_data", model_read(addr), got);
      tests++;
      $display("test %0d random fetch addr %h: %s", tests, addr, (errors == err0) ? "ok" : "FAIL");
    end
  endtask

  // **********************************************************************
  // main sequence and watchdog
  // **********************************************************************

  initial
  begin
    cache_mem_pkg::addr_t addr;
    cache_mem_pkg::word_t dummy;
    fetch_req  = 1'b0;
    fetch_addr = '0;
    data_req   = 1'b0;
    data_we    = 1'b0;
    data_be    = '0;
    data_addr  = '0;
    data_wdata = '0;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    seed       = 32'hdba5720c;
    // drawn in a fixed order before the two streams run
    for (int k = 0; k < N_RND; k++)
    begin
      rnd_d[k] = $random(seed);
      rnd_w[k] = $random(seed);
      rnd_i[k] = $random(seed);
    end
    load_table();
    wait (rst_n === 1'b1);
    for (int n = 0; n < N_TAB; n++)
    begin
      run_entry(n);
    end
    // fill pattern depends on the whole address
    for (int k = 0; k < N_PRE; k++)
    begin
      addr = 32'h300 + 32'(4 * k);
      data_op(1'b1, 4'hf, addr, addr ^ 32'ha5c3_0000, dummy);
      model_write(addr, 4'hf, addr ^ 32'ha5c3_0000);
    end
    $display("preload of %0d fetch words done", N_PRE);
    fork
      data_stream();
      fetch_stream();
    join
    $display("tests %0d checks %0d errors %0d", tests, checks, errors);
    if (errors == 0)
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

  initial
  begin
    #(LIMIT_CYC * CLK_NS);
    $display("timeout: still waiting for an ack from the DUT after %0d cycles", LIMIT_CYC);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- cache_mem.f
cache_mem_pkg.sv
shared_sram.sv
mem_bus_arbiter.sv
inst_fetch_port.sv
data_access_port.sv
cache_mem_top.sv
tb_clock_gen.sv
cache_mem_sva.sv
cache_mem_tb.sv

//--- Makefile
# Verilator flow for cache_mem
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= cache_mem_tb
FLIST     ?= cache_mem.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
JOBS      ?= 0

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FLIST)

# pass only when the log holds the pass line and no assertion error
sim: build
	-./$(BIN) | tee $(LOG)
	@grep -q "Regression passed" $(LOG) || (echo "simulation did not pass" && exit 1)
	@! grep -q "%Error" $(LOG) || (echo "assertion error in log" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
